//--- files.f
common/arm_isa_pkg.sv
common/core_bus_pkg.sv
decode/instr_decoder.sv
execute/alu_unit.sv
rtl/register_bank.sv
rtl/core_sequencer.sv
rtl/arm_core.sv
verification/tb_arm_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and sets the exit status from the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_arm_core -f files.f -o tb_arm_core \
    && ./obj_dir/tb_arm_core 2>&1 | tee sim.log \
    || { echo "simulation did not build or run"; exit 1; }
grep -q "Regression failed" sim.log && exit 1 || exit 0

//--- verification/tb_arm_core.sv
// testbench for arm_core; 1 KB memory that aliases above 0x3FC, each transfer waits 0-3 cycles
`default_nettype none

module tb_arm_core;
    timeunit 1ns;
    timeprecision 1ps;

    import arm_isa_pkg::*;
    import core_bus_pkg::*;

    localparam int          MEM_WORDS      = 256;
    localparam int          PROG_LEN       = 26;
    localparam int          WAIT_SLOTS     = 64;
    localparam int          BUS_TIMEOUT    = 20;   // cycles
    localparam int          RETIRE_TIMEOUT = 40;   // worst case near 13 cycles
    localparam int unsigned SEED           = 32'hbf6f9cc2;

    localparam word_t PROGRAM [PROG_LEN] = '{
        32'hE3A004FF, 32'hE3A01012, 32'hE3A02034, 32'hE0813002,  // 0x00 mov, add
        32'hE0424001, 32'hE0035002, 32'hE1816002, 32'hE0217002,  // 0x10 sub and orr eor
        32'hE1E08001, 32'hE0909000, 32'hE3A0A47F, 32'hE09AB00A,  // 0x20 mvn, adds pair
        32'hE051C002, 32'hE1520001, 32'hE1150001, 32'h13A0D001,  // 0x30 subs cmp tst movne
        32'h03A0D002, 32'hE5823100, 32'hE592E100, 32'hE3A04C03,  // 0x40 moveq, str, ldr
        32'hE5047010, 32'hE5145010, 32'hEA000000, 32'hE3A00055,  // 0x50 down offset, b
        32'hE3A01077, 32'hEAFFFFFE                               // 0x60 target, b to self
    };

    logic    clk = 1'b0;
    logic    dut_reset_n;
    wb_rsp_t dut_rsp = '0;
    wb_req_t dut_req;
    retire_t dut_retire;

    word_t       mem [MEM_WORDS];
    int unsigned wait_table [WAIT_SLOTS];  // wait cycles per request, drawn in turn
    int unsigned req_count     = 0;
    logic        busy;
    int unsigned wait_left;
    int          store_count   = 0;
    wb_req_t     expected_stores [$];
    retire_t     expected_retires [$];
    int          retire_errors = 0;
    int          store_errors  = 0;
    int          bus_errors    = 0;
    logic        timed_out     = 1'b0;

    always #20 clk = ~clk;

    arm_core u_arm_core (
        .clk       (clk),
        .i_reset_n (dut_reset_n),
        .i_bus     (dut_rsp),
        .o_bus     (dut_req),
        .o_retire  (dut_retire)
    );

    // memory model reloaded while reset is held
    always @(negedge clk) begin
        if (dut_reset_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] = 32'hF000_0000 | (i * 4);  // NV filler tagged with its address
            end
            for (int i = 0; i < PROG_LEN; i++) begin
                mem[i] = PROGRAM[i];
            end
            dut_rsp.ack = 1'b0;
            busy        = 1'b0;
        end else if (dut_rsp.ack) begin
            dut_rsp.ack = 1'b0;                    // one ack per request
        end else if (dut_req.cyc && dut_req.stb) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = wait_table[req_count % WAIT_SLOTS];
                req_count++;
            end
            if (wait_left == 0) begin
                busy = 1'b0;
                if (dut_req.we) begin
                    mem[dut_req.adr[9:2]] = dut_req.dat_w;
                    if (store_count < expected_stores.size()) begin
                        check_store(store_count, expected_stores[store_count], dut_req);
                    end else begin
                        store_errors++;
                        $display("CHECK FAILED at %0t: unexpected store to %h",
                                 $time, dut_req.adr);
                    end
                    store_count++;
                end else begin
                    dut_rsp.dat_r = mem[dut_req.adr[9:2]];
                end
                dut_rsp.ack = 1'b1;
            end else begin
                wait_left--;
            end
        end
    end

    task automatic expect_retire(input word_t pc, input logic wr_en, input reg_idx_t rd,
                                 input word_t value, input flags_t flags);
        retire_t entry;
        entry.valid = 1'b1;
        entry.pc    = pc;
        entry.wr_en = wr_en;
        entry.rd    = rd;
        entry.value = value;
        entry.flags = flags;
        expected_retires.push_back(entry);
    endtask

    task automatic expect_store(input word_t adr, input word_t data);
        wb_req_t entry;
        entry.cyc   = 1'b1;
        entry.stb   = 1'b1;
        entry.we    = 1'b1;
        entry.adr   = adr;
        entry.dat_w = data;
        expected_stores.push_back(entry);
    endtask

    task automatic load_expected();
        expect_retire(32'h00, 1'b1, 4'd0,  32'hFF000000, 4'b0000);  // rotated immediate
        expect_retire(32'h04, 1'b1, 4'd1,  32'h00000012, 4'b0000);
        expect_retire(32'h08, 1'b1, 4'd2,  32'h00000034, 4'b0000);
        expect_retire(32'h0C, 1'b1, 4'd3,  32'h00000046, 4'b0000);
        expect_retire(32'h10, 1'b1, 4'd4,  32'h00000022, 4'b0000);
        expect_retire(32'h14, 1'b1, 4'd5,  32'h00000004, 4'b0000);
        expect_retire(32'h18, 1'b1, 4'd6,  32'h00000036, 4'b0000);
        expect_retire(32'h1C, 1'b1, 4'd7,  32'h00000026, 4'b0000);
        expect_retire(32'h20, 1'b1, 4'd8,  32'hFFFFFFED, 4'b0000);
        expect_retire(32'h24, 1'b1, 4'd9,  32'hFE000000, 4'b1010);  // carry out
        expect_retire(32'h28, 1'b1, 4'd10, 32'h7F000000, 4'b1010);
        expect_retire(32'h2C, 1'b1, 4'd11, 32'hFE000000, 4'b1001);  // signed overflow
        expect_retire(32'h30, 1'b1, 4'd12, 32'hFFFFFFDE, 4'b1000);  // borrow clears C
        expect_retire(32'h34, 1'b0, 4'd0,  32'h00000000, 4'b0010);
        expect_retire(32'h38, 1'b0, 4'd0,  32'h00000000, 4'b0110);  // tst gives zero
        expect_retire(32'h3C, 1'b0, 4'd13, 32'h00000000, 4'b0110);  // ne fails
        expect_retire(32'h40, 1'b1, 4'd13, 32'h00000002, 4'b0110);
        expect_retire(32'h44, 1'b0, 4'd3,  32'h00000000, 4'b0110);
        expect_retire(32'h48, 1'b1, 4'd14, 32'h00000046, 4'b0110);
        expect_retire(32'h4C, 1'b1, 4'd4,  32'h00000300, 4'b0110);
        expect_retire(32'h50, 1'b0, 4'd7,  32'h00000000, 4'b0110);
        expect_retire(32'h54, 1'b1, 4'd5,  32'h00000026, 4'b0110);
        expect_retire(32'h58, 1'b0, 4'd0,  32'h00000000, 4'b0110);
        expect_retire(32'h60, 1'b1, 4'd1,  32'h00000077, 4'b0110);  // 0x5C skipped
        expect_retire(32'h64, 1'b0, 4'd15, 32'h00000000, 4'b0110);
        expect_retire(32'h64, 1'b0, 4'd15, 32'h00000000, 4'b0110);
        expect_store(32'h134, 32'h00000046);
        expect_store(32'h2F0, 32'h00000026);                        // U = 0
    endtask

    task automatic check_retire(input int idx, input retire_t exp, input retire_t act);
        if (act !== exp) begin
            retire_errors++;
            $display("CHECK FAILED at %0t: retire %0d expected pc %h wr %b rd %0d val %h nzcv %b",
                     $time, idx, exp.pc, exp.wr_en, exp.rd, exp.value, exp.flags);
            $display("    got pc %h wr %b rd %0d val %h nzcv %b",
                     act.pc, act.wr_en, act.rd, act.value, act.flags);
        end
    endtask

    task automatic check_store(input int idx, input wb_req_t exp, input wb_req_t act);
        if (act !== exp) begin
            store_errors++;
            $display("CHECK FAILED at %0t: store %0d expected adr %h data %h, got adr %h data %h",
                     $time, idx, exp.adr, exp.dat_w, act.adr, act.dat_w);
        end
    endtask

    initial begin
        int   cycles;
        logic seen;
        dut_reset_n = 1'b1;
        void'($urandom(SEED));
        for (int i = 0; i < WAIT_SLOTS; i++) begin
            wait_table[i] = $urandom_range(3, 0);
        end
        load_expected();
        repeat (4) begin
            @(negedge clk);
            if (dut_retire.valid || dut_req.cyc) begin
                bus_errors++;
                $display("CHECK FAILED at %0t: bus or retire active during reset", $time);
            end
        end
        dut_reset_n = 1'b0;
        cycles = 0;
        while (!dut_req.cyc && cycles < BUS_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!dut_req.cyc) begin
            timed_out = 1'b1;
            $display("timeout: no bus request after reset release");
        end else if (dut_req.we || dut_req.adr != 32'h0) begin
            bus_errors++;
            $display("CHECK FAILED at %0t: first request expected read of 0, got we %b adr %h",
                     $time, dut_req.we, dut_req.adr);
        end
        for (int i = 0; i < expected_retires.size() && !timed_out; i++) begin
            cycles = 0;
            seen   = 1'b0;
            while (!seen && cycles < RETIRE_TIMEOUT) begin
                @(negedge clk);
                seen = dut_retire.valid;
                cycles++;
            end
            if (!seen) begin
                timed_out = 1'b1;
                $display("timeout: retire %0d did not arrive", i);
            end else begin
                check_retire(i, expected_retires[i], dut_retire);
            end
        end
        if (store_count != expected_stores.size()) begin
            store_errors++;
            $display("CHECK FAILED at %0t: expected %0d stores, memory saw %0d",
                     $time, expected_stores.size(), store_count);
        end
        $display("errors: retire %0d, store %0d, bus %0d, timeout %0d",
                 retire_errors, store_errors, bus_errors, timed_out);
        if (timed_out || (retire_errors + store_errors + bus_errors) != 0) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/arm_core.sv
// multi-cycle core with one Wishbone master; held in reset while i_reset_n is high
`default_nettype none

module arm_core (
    input  logic                  clk,
    input  logic                  i_reset_n,
    input  core_bus_pkg::wb_rsp_t i_bus,
    output core_bus_pkg::wb_req_t o_bus,
    output core_bus_pkg::retire_t o_retire
);
    import arm_isa_pkg::*;
    import core_bus_pkg::*;

    decoded_t dec;
    word_t    instr;
    flags_t   flags;
    reg_idx_t rn_idx;
    reg_idx_t rm_idx;
    word_t    rn_value;
    word_t    rm_value;     // Rd value when the instruction is a store
    word_t    operand_a;
    word_t    alu_result;
    flags_t   alu_flags;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;

    core_sequencer u_core_sequencer (
        .clk          (clk),
        .i_reset_n    (i_reset_n),
        .i_dec        (dec),
        .i_rn_value   (rn_value),
        .i_rm_value   (rm_value),
        .i_alu_result (alu_result),
        .i_alu_flags  (alu_flags),
        .i_bus        (i_bus),
        .o_bus        (o_bus),
        .o_instr      (instr),
        .o_flags      (flags),
        .o_rn_idx     (rn_idx),
        .o_rm_idx     (rm_idx),
        .o_operand_a  (operand_a),
        .o_wr_en      (wr_en),
        .o_wr_idx     (wr_idx),
        .o_wr_data    (wr_data),
        .o_retire     (o_retire)
    );

    instr_decoder u_instr_decoder (
        .i_instr (instr),
        .i_flags (flags),
        .o_dec   (dec)
    );

    alu_unit u_alu_unit (
        .i_op       (dec.alu_op),
        .i_op2_sel  (dec.op2_sel),
        .i_a        (operand_a),
        .i_rm_value (rm_value),
        .i_imm12    (dec.imm12),
        .i_flags    (flags),
        .o_result   (alu_result),
        .o_flags    (alu_flags)
    );

    register_bank u_register_bank (
        .clk         (clk),
        .i_reset_n   (i_reset_n),
        .i_rd_idx_a  (rn_idx),
        .i_rd_idx_b  (rm_idx),
        .i_wr_en     (wr_en),
        .i_wr_idx    (wr_idx),
        .i_wr_data   (wr_data),
        .o_rd_data_a (rn_value),
        .o_rd_data_b (rm_value)
    );

endmodule

`default_nettype wire

//--- rtl/core_sequencer.sv
// one instruction in flight; pc+8 replaces r15 for Rn and store data but not for Rm of data ops
`default_nettype none

module core_sequencer (
    input  logic                   clk,
    input  logic                   i_reset_n,
    input  core_bus_pkg::decoded_t i_dec,
    input  arm_isa_pkg::word_t     i_rn_value,
    input  arm_isa_pkg::word_t     i_rm_value,
    input  arm_isa_pkg::word_t     i_alu_result,
    input  arm_isa_pkg::flags_t    i_alu_flags,
    input  core_bus_pkg::wb_rsp_t  i_bus,
    output core_bus_pkg::wb_req_t  o_bus,
    output arm_isa_pkg::word_t     o_instr,
    output arm_isa_pkg::flags_t    o_flags,
    output arm_isa_pkg::reg_idx_t  o_rn_idx,
    output arm_isa_pkg::reg_idx_t  o_rm_idx,
    output arm_isa_pkg::word_t     o_operand_a,
    output logic                   o_wr_en,
    output arm_isa_pkg::reg_idx_t  o_wr_idx,
    output arm_isa_pkg::word_t     o_wr_data,
    output core_bus_pkg::retire_t  o_retire
);
    import arm_isa_pkg::*;
    import core_bus_pkg::*;

    seq_state_e state;
    word_t      pc;
    word_t      instr_q;
    word_t      load_q;
    flags_t     flags_q;
    logic       req_active;   // drives cyc and stb
    logic       req_we;
    word_t      req_adr;
    word_t      req_dat_w;
    word_t      pc_plus8;
    word_t      branch_off;
    word_t      next_pc;
    word_t      store_data;
    word_t      commit_value;
    flags_t     flags_next;
    logic       is_store;
    logic       mem_access;
    logic       wr_commit;

    assign pc_plus8   = pc + 32'd8;
    assign branch_off = {{6{i_dec.imm24[23]}}, i_dec.imm24, 2'b00};
    assign is_store   = (i_dec.kind == KIND_STORE);
    assign mem_access = i_dec.cond_pass && (is_store || i_dec.kind == KIND_LOAD);
    assign wr_commit  = i_dec.cond_pass && (i_dec.rd != reg_idx_t'(PC_REG)) &&
                        (i_dec.kind == KIND_DATA || i_dec.kind == KIND_LOAD);
    assign next_pc    = (i_dec.cond_pass && i_dec.kind == KIND_BRANCH) ?
                        pc_plus8 + branch_off : pc + 32'd4;
    assign flags_next = (i_dec.cond_pass && i_dec.set_flags) ? i_alu_flags : flags_q;
    assign store_data = (i_dec.rd == reg_idx_t'(PC_REG)) ? pc_plus8 : i_rm_value;

    always_comb begin
        if (!wr_commit) begin
            commit_value = '0;
        end else if (i_dec.kind == KIND_LOAD) begin
            commit_value = load_q;
        end else begin
            commit_value = i_alu_result;
        end
    end

    assign o_instr     = instr_q;
    assign o_flags     = flags_q;
    assign o_rn_idx    = i_dec.rn;
    assign o_rm_idx    = is_store ? i_dec.rd : i_dec.rm;  // store source rides port b
    assign o_operand_a = (i_dec.rn == reg_idx_t'(PC_REG)) ? pc_plus8 : i_rn_value;
    assign o_wr_en     = (state == ST_RETIRE) && wr_commit;
    assign o_wr_idx    = i_dec.rd;
    assign o_wr_data   = commit_value;

    always_comb begin
        o_bus.cyc   = req_active;
        o_bus.stb   = req_active;
        o_bus.we    = req_we;
        o_bus.adr   = req_adr;
        o_bus.dat_w = req_dat_w;
    end

    always_comb begin
        o_retire.valid = (state == ST_RETIRE);
        o_retire.pc    = pc;
        o_retire.wr_en = wr_commit;
        o_retire.rd    = i_dec.rd;
        o_retire.value = commit_value;
        o_retire.flags = flags_next;
    end

    always_ff @(posedge clk or posedge i_reset_n) begin
        if (i_reset_n) begin
            state      <= ST_FETCH;
            pc         <= '0;
            flags_q    <= '0;
            req_active <= 1'b0;
            req_we     <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (!req_active) begin
                        req_active <= 1'b1;  // first fetch after reset
                        req_we     <= 1'b0;
                    end else if (i_bus.ack) begin
                        req_active <= 1'b0;
                        state      <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (mem_access) begin
                        req_active <= 1'b1;
                        req_we     <= is_store;
                        state      <= ST_MEM;
                    end else begin
                        state <= ST_RETIRE;
                    end
                end
                ST_MEM: begin
                    if (i_bus.ack) begin
                        req_active <= 1'b0;
                        state      <= ST_RETIRE;
                    end
                end
                default: begin
                    pc         <= next_pc;
                    flags_q    <= flags_next;
                    req_active <= 1'b1;  // next fetch launches straight away
                    req_we     <= 1'b0;
                    state      <= ST_FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FETCH && !req_active) begin
            req_adr <= pc;
        end
        if (state == ST_FETCH && req_active && i_bus.ack) begin
            instr_q <= i_bus.dat_r;
        end
        if (state == ST_EXEC && mem_access) begin
            req_adr   <= i_alu_result;  // ALU forms Rn +/- imm12
            req_dat_w <= store_data;
        end
        if (state == ST_MEM && i_bus.ack && !req_we) begin
            load_q <= i_bus.dat_r;
        end
        if (state == ST_RETIRE) begin
            req_adr <= next_pc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/register_bank.sv
// r0-r14 only; index 15 reads as zero here and writes to it are ignored
`default_nettype none

module register_bank (
    input  logic                  clk,
    input  logic                  i_reset_n,
    input  arm_isa_pkg::reg_idx_t i_rd_idx_a,
    input  arm_isa_pkg::reg_idx_t i_rd_idx_b,
    input  logic                  i_wr_en,
    input  arm_isa_pkg::reg_idx_t i_wr_idx,
    input  arm_isa_pkg::word_t    i_wr_data,
    output arm_isa_pkg::word_t    o_rd_data_a,
    output arm_isa_pkg::word_t    o_rd_data_b
);
    import arm_isa_pkg::*;

    word_t regs [NUM_REGS];

    assign o_rd_data_a = (i_rd_idx_a < NUM_REGS) ? regs[i_rd_idx_a] : '0;
    assign o_rd_data_b = (i_rd_idx_b < NUM_REGS) ? regs[i_rd_idx_b] : '0;

    always_ff @(posedge clk or posedge i_reset_n) begin
        if (i_reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_idx < NUM_REGS)) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

endmodule

`default_nettype wire

//--- execute/alu_unit.sv
// combinational; no shifter, so logical ops keep C and V from the incoming flags
`default_nettype none

module alu_unit (
    input  arm_isa_pkg::alu_op_e   i_op,
    input  core_bus_pkg::op2_sel_e i_op2_sel,
    input  arm_isa_pkg::word_t     i_a,
    input  arm_isa_pkg::word_t     i_rm_value,
    input  logic [11:0]            i_imm12,
    input  arm_isa_pkg::flags_t    i_flags,
    output arm_isa_pkg::word_t     o_result,
    output arm_isa_pkg::flags_t    o_flags
);
    import arm_isa_pkg::*;
    import core_bus_pkg::*;

    word_t           imm8_ext;
    logic [4:0]      rot_amt;
    word_t           rot_imm;
    word_t           op_b;
    logic [WORD_W:0] sum;
    logic [WORD_W:0] diff;

    assign imm8_ext = {24'b0, i_imm12[7:0]};
    assign rot_amt  = {i_imm12[11:8], 1'b0};  // twice the rotate field
    assign rot_imm  = (imm8_ext >> rot_amt) | (imm8_ext << (6'd32 - rot_amt));

    always_comb begin
        case (i_op2_sel)
            OP2_ROT_IMM:  op_b = rot_imm;
            OP2_OFFSET12: op_b = {20'b0, i_imm12};
            default:      op_b = i_rm_value;
        endcase
    end

    assign sum  = {1'b0, i_a} + {1'b0, op_b};
    assign diff = {1'b0, i_a} + {1'b0, ~op_b} + 33'd1;  // top bit is not-borrow

    always_comb begin
        o_flags.c = i_flags.c;
        o_flags.v = i_flags.v;
        case (i_op)
            ALU_MVN: o_result = ~op_b;
            ALU_ADD: begin
                o_result  = sum[WORD_W-1:0];
                o_flags.c = sum[WORD_W];
                o_flags.v = (i_a[WORD_W-1] == op_b[WORD_W-1]) &&
                            (sum[WORD_W-1] != i_a[WORD_W-1]);
            end
            ALU_SUB: begin
                o_result  = diff[WORD_W-1:0];
                o_flags.c = diff[WORD_W];
                o_flags.v = (i_a[WORD_W-1] != op_b[WORD_W-1]) &&
                            (diff[WORD_W-1] != i_a[WORD_W-1]);
            end
            ALU_AND: o_result = i_a & op_b;
            ALU_ORR: o_result = i_a | op_b;
            ALU_EOR: o_result = i_a ^ op_b;
            default: o_result = op_b;  // MOV
        endcase
        o_flags.n = o_result[WORD_W-1];
        o_flags.z = (o_result == '0);
    end

endmodule

`default_nettype wire

//--- decode/instr_decoder.sv
// combinational; unkept opcodes and type 11 decode as no-op, condition NV never passes
`default_nettype none

module instr_decoder (
    input  arm_isa_pkg::word_t     i_instr,
    input  arm_isa_pkg::flags_t    i_flags,
    output core_bus_pkg::decoded_t o_dec
);
    import arm_isa_pkg::*;
    import core_bus_pkg::*;

    cond_e      cond;
    logic [1:0] instr_type;
    logic       imm_bit;
    dp_opcode_e opcode;
    logic       sl_bit;
    logic       u_bit;
    logic       cond_ok;

    assign cond       = cond_e'(i_instr[COND_LSB +: 4]);
    assign instr_type = i_instr[TYPE_LSB +: 2];
    assign imm_bit    = i_instr[IMM_BIT];
    assign opcode     = dp_opcode_e'(i_instr[OPCODE_LSB +: 4]);
    assign sl_bit     = i_instr[SL_BIT];
    assign u_bit      = i_instr[U_BIT];

    always_comb begin
        case (cond)
            COND_EQ: cond_ok = i_flags.z;
            COND_NE: cond_ok = !i_flags.z;
            COND_CS: cond_ok = i_flags.c;
            COND_CC: cond_ok = !i_flags.c;
            COND_MI: cond_ok = i_flags.n;
            COND_PL: cond_ok = !i_flags.n;
            COND_VS: cond_ok = i_flags.v;
            COND_VC: cond_ok = !i_flags.v;
            COND_HI: cond_ok = i_flags.c && !i_flags.z;
            COND_LS: cond_ok = !i_flags.c || i_flags.z;
            COND_GE: cond_ok = (i_flags.n == i_flags.v);
            COND_LT: cond_ok = (i_flags.n != i_flags.v);
            COND_GT: cond_ok = !i_flags.z && (i_flags.n == i_flags.v);
            COND_LE: cond_ok = i_flags.z || (i_flags.n != i_flags.v);
            COND_AL: cond_ok = 1'b1;
            default: cond_ok = 1'b0;  // NV
        endcase
    end

    always_comb begin
        o_dec.kind      = KIND_NOP;
        o_dec.alu_op    = ALU_MOV;
        o_dec.op2_sel   = imm_bit ? OP2_ROT_IMM : OP2_REG;
        o_dec.rn        = i_instr[RN_LSB +: REG_IDX_W];
        o_dec.rm        = i_instr[RM_LSB +: REG_IDX_W];
        o_dec.rd        = i_instr[RD_LSB +: REG_IDX_W];
        o_dec.imm12     = i_instr[IMM12_LSB +: 12];
        o_dec.imm24     = i_instr[IMM24_LSB +: 24];
        o_dec.set_flags = 1'b0;
        o_dec.cond_pass = cond_ok;
        case (instr_type)
            2'b00: begin
                o_dec.kind      = KIND_DATA;
                o_dec.set_flags = sl_bit;
                case (opcode)
                    OP_MOV: o_dec.alu_op = ALU_MOV;
                    OP_MVN: o_dec.alu_op = ALU_MVN;
                    OP_ADD: o_dec.alu_op = ALU_ADD;
                    OP_SUB: o_dec.alu_op = ALU_SUB;
                    OP_AND: o_dec.alu_op = ALU_AND;
                    OP_ORR: o_dec.alu_op = ALU_ORR;
                    OP_EOR: o_dec.alu_op = ALU_EOR;
                    OP_CMP: begin
                        o_dec.kind      = KIND_COMPARE;
                        o_dec.alu_op    = ALU_SUB;
                        o_dec.set_flags = 1'b1;
                    end
                    OP_TST: begin
                        o_dec.kind      = KIND_COMPARE;
                        o_dec.alu_op    = ALU_AND;
                        o_dec.set_flags = 1'b1;
                    end
                    default: begin
                        o_dec.kind      = KIND_NOP;  // ADC, SBC and friends
                        o_dec.set_flags = 1'b0;
                    end
                endcase
            end
            2'b01: begin
                o_dec.kind    = sl_bit ? KIND_LOAD : KIND_STORE;
                o_dec.alu_op  = u_bit ? ALU_ADD : ALU_SUB;  // pre-indexed, no writeback
                o_dec.op2_sel = OP2_OFFSET12;
            end
            2'b10: o_dec.kind = KIND_BRANCH;
            default: o_dec.kind = KIND_NOP;
        endcase
    end

endmodule

`default_nettype wire

//--- common/core_bus_pkg.sv
// Wishbone classic subset without sel or err; every transfer is one aligned 32-bit word
`default_nettype none

package core_bus_pkg;

    import arm_isa_pkg::*;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;    // byte address, bits 1:0 always zero
        word_t dat_w;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat_r;  // valid in the ack cycle of a read
    } wb_rsp_t;

    typedef enum logic [2:0] {
        KIND_DATA, KIND_COMPARE, KIND_LOAD, KIND_STORE, KIND_BRANCH, KIND_NOP
    } instr_kind_e;

    typedef enum logic [1:0] {
        OP2_REG, OP2_ROT_IMM, OP2_OFFSET12
    } op2_sel_e;

    typedef struct packed {
        instr_kind_e kind;
        alu_op_e     alu_op;
        op2_sel_e    op2_sel;
        reg_idx_t    rn;
        reg_idx_t    rm;
        reg_idx_t    rd;
        logic [11:0] imm12;
        logic [23:0] imm24;
        logic        set_flags;
        logic        cond_pass;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        logic     wr_en;
        reg_idx_t rd;
        word_t    value;   // zero when wr_en is low
        flags_t   flags;   // flags after the instruction
    } retire_t;

    typedef enum logic [1:0] {
        ST_FETCH, ST_EXEC, ST_MEM, ST_RETIRE
    } seq_state_e;

endpackage

`default_nettype wire

//--- common/arm_isa_pkg.sv
// ARM32 subset encodings only; shifted operands, ADC/SBC and the NV condition are not encoded
`default_nettype none

package arm_isa_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 4;
    localparam int NUM_REGS  = 15;  // r0..r14 held in the bank
    localparam int PC_REG    = 15;

    localparam int COND_LSB   = 28;  // cond[31:28]
    localparam int TYPE_LSB   = 26;  // type[27:26]
    localparam int IMM_BIT    = 25;  // 1 = rotated immediate
    localparam int OPCODE_LSB = 21;  // opcode[24:21]
    localparam int U_BIT      = 23;  // ldr/str offset direction
    localparam int SL_BIT     = 20;  // S for data ops, L for memory ops
    localparam int RN_LSB     = 16;
    localparam int RD_LSB     = 12;
    localparam int RM_LSB     = 0;
    localparam int IMM12_LSB  = 0;
    localparam int IMM24_LSB  = 0;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL
    } cond_e;

    typedef enum logic [3:0] {
        OP_AND = 4'b0000,
        OP_EOR = 4'b0001,
        OP_SUB = 4'b0010,
        OP_ADD = 4'b0100,
        OP_TST = 4'b1000,
        OP_CMP = 4'b1010,
        OP_ORR = 4'b1100,
        OP_MOV = 4'b1101,
        OP_MVN = 4'b1111
    } dp_opcode_e;

    typedef enum logic [2:0] {
        ALU_MOV, ALU_MVN, ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR, ALU_EOR
    } alu_op_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

endpackage

`default_nettype wire
